// ==== flist.f ====
hw/cpuIsaPkg.sv
hw/memSysPkg.sv
hw/nextPcUnit.sv
hw/dataCache.sv
hw/mainMemory.sv
hw/memSystem.sv
hw/memoryStage.sv
testbench/memoryStageChecker.sv
testbench/memoryStageTb.sv

// ==== testbench/memoryStageTb.sv ====
// memory stage testbench
`timescale 1ns/1ns
`default_nettype none

module memoryStageTb;

   localparam int NUM_OPS    = 400;
   localparam int CLK_PERIOD = 100;
   // worst access is a read miss plus the turnaround edge
   localparam int OP_CYCLES  = 2 * memSysPkg::MEM_LATENCY + 4;
   localparam int WAIT_LIMIT = 4 * memSysPkg::MEM_LATENCY + 10;
   localparam int RUN_LIMIT  = (NUM_OPS * OP_CYCLES + 50) * CLK_PERIOD;

   logic               clk;
   logic               rstN;
   cpuIsaPkg::pcIn_t   pcIn;
   cpuIsaPkg::pcCtrl_t pcCtrl;
   logic               memRead;
   logic               memWrite;
   cpuIsaPkg::word_t   writeData;
   cpuIsaPkg::word_t   nextPc;
   logic               flush;
   cpuIsaPkg::word_t   readData;
   logic               isUnaligned;
   logic               stallDMem;
   logic               memDone;
   logic               cacheHit;
   int                 checkCount;
   int                 errCount;
   // hangs seen by the stimulus itself
   int                 tbErrors;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   memoryStage i_dut (
      .clk         (clk),
      .rstN        (rstN),
      .pcIn        (pcIn),
      .pcCtrl      (pcCtrl),
      .memRead     (memRead),
      .memWrite    (memWrite),
      .writeData   (writeData),
      .nextPc      (nextPc),
      .flush       (flush),
      .readData    (readData),
      .isUnaligned (isUnaligned),
      .stallDMem   (stallDMem),
      .memDone     (memDone),
      .cacheHit    (cacheHit)
   );

   memoryStageChecker uChecker (
      .clk         (clk),
      .rstN        (rstN),
      .pcIn        (pcIn),
      .pcCtrl      (pcCtrl),
      .memRead     (memRead),
      .memWrite    (memWrite),
      .writeData   (writeData),
      .nextPc      (nextPc),
      .flush       (flush),
      .readData    (readData),
      .isUnaligned (isUnaligned),
      .stallDMem   (stallDMem),
      .memDone     (memDone),
      .cacheHit    (cacheHit),
      .checkCount  (checkCount),
      .errCount    (errCount)
   );

   // four tags on four indexes, so hits and conflicts both happen
   function automatic cpuIsaPkg::word_t randomAddr(input logic odd);
      logic [memSysPkg::TAG_W-1:0]   tg;
      logic [memSysPkg::INDEX_W-1:0] idx;
      logic                          wordSel;
      tg      = memSysPkg::TAG_W'($urandom_range(3));
      idx     = memSysPkg::INDEX_W'($urandom_range(3) * 3);
      wordSel = 1'($urandom_range(1));
      return {tg, idx, wordSel, odd};
   endfunction

   // pc operands and controls, immediates sign extended
   task automatic randomizePc();
      logic [7:0]  imm8;
      logic [10:0] imm11;
      imm8  = 8'($urandom);
      imm11 = 11'($urandom);
      pcIn.pcAdd    <= 16'($urandom) & 16'hfffe;
      pcIn.imm8Ext  <= {{8{imm8[7]}}, imm8};
      pcIn.imm11Ext <= {{5{imm11[10]}}, imm11};
      pcCtrl        <= 3'($urandom);
   endtask

   // request stays held until done is seen
   task automatic waitForDone();
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!memDone && cycles < WAIT_LIMIT);
      if (!memDone) begin
         tbErrors++;
         $display("ERROR: memDone did not arrive within %0d cycles at %0t", WAIT_LIMIT, $time);
      end
   endtask

   task automatic runOperation();
      int kind;
      int sel;
      kind = $urandom_range(99);
      sel  = $urandom_range(2);
      @(posedge clk);
      randomizePc();
      writeData <= 16'($urandom);
      if (kind < 15) begin
         // odd address gets one cycle only, any command mix
         pcIn.aluResult <= randomAddr(1'b1);
         memRead        <= (sel != 1);
         memWrite       <= (sel != 0);
      end else begin
         pcIn.aluResult <= randomAddr(1'b0);
         // both set is the error case
         memRead        <= (kind < 65);
         memWrite       <= (kind < 25) || (kind >= 65);
         waitForDone();
      end
   endtask

   initial begin
      void'($urandom(32'hda8e));
      rstN      = 1'b0;
      pcIn      = '0;
      pcCtrl    = '0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      writeData = '0;
      tbErrors  = 0;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      for (int i = 0; i < NUM_OPS; i++) begin
         runOperation();
      end
      @(posedge clk);
      memRead  <= 1'b0;
      memWrite <= 1'b0;
      repeat (3) @(posedge clk);
      $display("checks: %0d  checker errors: %0d  stimulus errors: %0d",
               checkCount, errCount, tbErrors);
      if (errCount == 0 && tbErrors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // whole run bound
   initial begin
      #(RUN_LIMIT);
      $display("ERROR: watchdog expired after %0d ns, run stopped", RUN_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/memoryStageChecker.sv ====
// memory stage reference model
`timescale 1ns/1ns
`default_nettype none

module memoryStageChecker (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire cpuIsaPkg::pcIn_t   pcIn,
   input  wire cpuIsaPkg::pcCtrl_t pcCtrl,
   input  wire logic               memRead,
   input  wire logic               memWrite,
   input  wire cpuIsaPkg::word_t   writeData,
   input  wire cpuIsaPkg::word_t   nextPc,
   input  wire logic               flush,
   input  wire cpuIsaPkg::word_t   readData,
   input  wire logic               isUnaligned,
   input  wire logic               stallDMem,
   input  wire logic               memDone,
   input  wire logic               cacheHit,
   output int                      checkCount,
   output int                      errCount
);

   // model main memory is word addressed and starts cleared like the real one
   cpuIsaPkg::word_t modelMem [memSysPkg::MEM_WORDS];
   // model cache directory with data implied by modelMem
   logic [memSysPkg::LINES-1:0] modelValid;
   logic [memSysPkg::TAG_W-1:0] modelTag [memSysPkg::LINES];
   // both-set request seen last cycle and due for its error answer
   logic errArmed;

   initial begin
      checkCount = 0;
      errCount   = 0;
      modelValid = '0;
      errArmed   = 1'b0;
      for (int i = 0; i < memSysPkg::MEM_WORDS; i++) begin
         modelMem[i] = '0;
      end
   end

   // jump beats branch, branch beats fall through
   function automatic cpuIsaPkg::word_t predictNextPc(input cpuIsaPkg::pcIn_t p,
                                                      input cpuIsaPkg::pcCtrl_t c);
      cpuIsaPkg::word_t offset;
      offset = c.immSrc ? p.imm11Ext : p.imm8Ext;
      if (c.aluJump) return p.aluResult;
      if (c.brchCnd) return p.pcAdd + offset;
      return p.pcAdd;
   endfunction

   task automatic compareWord(input string name, input cpuIsaPkg::word_t expVal,
                              input cpuIsaPkg::word_t actVal);
      checkCount++;
      if (expVal !== actVal) begin
         errCount++;
         $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expVal, actVal, $time);
      end
   endtask

   // outputs are settled half a cycle after the drive edge
   always @(negedge clk) begin : modelCheck
      logic                          aligned;
      logic                          validReq;
      logic                          bothSet;
      logic [memSysPkg::INDEX_W-1:0] idx;
      logic [memSysPkg::TAG_W-1:0]   tg;
      logic [memSysPkg::MEM_ADDR_W-1:0] wAddr;
      logic                          predHit;
      logic                          expUnal;
      if (!rstN) begin
         modelValid = '0;
         errArmed   = 1'b0;
      end else begin
         aligned  = !pcIn.aluResult[0];
         validReq = (memRead || memWrite) && aligned;
         bothSet  = memRead && memWrite && aligned;
         idx      = pcIn.aluResult[memSysPkg::OFFSET_W +: memSysPkg::INDEX_W];
         tg       = pcIn.aluResult[memSysPkg::OFFSET_W + memSysPkg::INDEX_W +: memSysPkg::TAG_W];
         wAddr    = pcIn.aluResult[cpuIsaPkg::WORD_W-1:1];
         predHit  = modelValid[idx] && (modelTag[idx] == tg);

         // pc path is combinational
         compareWord("nextPc", predictNextPc(pcIn, pcCtrl), nextPc);
         compareWord("flush", 16'(pcCtrl.brchCnd || pcCtrl.aluJump), 16'(flush));

         // odd request flagged at once, both-set one cycle after it appears
         expUnal = ((memRead || memWrite) && !aligned) || errArmed;
         compareWord("isUnaligned", 16'(expUnal), 16'(isUnaligned));

         // error answer comes with its done
         if (errArmed) begin
            compareWord("memDone", 16'h1, 16'(memDone));
         end
         errArmed = bothSet && !errArmed;

         // idle memory side stays quiet
         if (!validReq) begin
            compareWord("stallDMem", 16'h0, 16'(stallDMem));
            compareWord("memDone", 16'h0, 16'(memDone));
         end

         // a predicted read hit never stalls
         if (memRead && !memWrite && aligned && predHit) begin
            compareWord("stallDMem", 16'h0, 16'(stallDMem));
         end

         if (validReq && memDone) begin
            if (memRead && memWrite) begin
               // error answer and no access at all
               compareWord("cacheHit", 16'h0, 16'(cacheHit));
            end else if (memRead) begin
               compareWord("cacheHit", 16'(predHit), 16'(cacheHit));
               compareWord("readData", modelMem[wAddr], readData);
               // miss allocates the line
               modelValid[idx] = 1'b1;
               modelTag[idx]   = tg;
            end else begin
               compareWord("cacheHit", 16'(predHit), 16'(cacheHit));
               // write-through without allocate
               modelMem[wAddr] = writeData;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/memoryStage.sv ====
// processor memory stage
`timescale 1ns/1ns
`default_nettype none

module memoryStage (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire cpuIsaPkg::pcIn_t   pcIn,
   input  wire cpuIsaPkg::pcCtrl_t pcCtrl,
   input  wire logic               memRead,
   input  wire logic               memWrite,
   input  wire cpuIsaPkg::word_t   writeData,
   output cpuIsaPkg::word_t        nextPc,
   output logic                    flush,
   output cpuIsaPkg::word_t        readData,
   output logic                    isUnaligned,
   output logic                    stallDMem,
   output logic                    memDone,
   output logic                    cacheHit
);

   // data address is the alu result
   logic                oddAddr;
   memSysPkg::memReq_t  memReq;
   memSysPkg::memResp_t memResp;

   // branch and jump resolution
   nextPcUnit uNextPc (
      .pcIn   (pcIn),
      .pcCtrl (pcCtrl),
      .nextPc (nextPc),
      .flush  (flush)
   );

   assign oddAddr = pcIn.aluResult[0];

   // odd word address never reaches the cache
   always_comb begin
      memReq.rd    = memRead && !oddAddr;
      memReq.wr    = memWrite && !oddAddr;
      memReq.addr  = pcIn.aluResult;
      memReq.wdata = writeData;
   end

   memSystem uMemSys (
      .clk  (clk),
      .rstN (rstN),
      .req  (memReq),
      .resp (memResp)
   );

   assign readData  = memResp.rdata;
   assign stallDMem = memResp.stall;
   assign memDone   = memResp.done;
   assign cacheHit  = memResp.hit;

   // blocked odd access, or rd and wr together flagged by the cache
   assign isUnaligned = memResp.err || ((memRead || memWrite) && oddAddr);

endmodule

`default_nettype wire

// ==== hw/memSystem.sv ====
// cache and main memory
`timescale 1ns/1ns
`default_nettype none

module memSystem (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire memSysPkg::memReq_t req,
   output memSysPkg::memResp_t     resp
);

   // cache to memory link
   memSysPkg::mainReq_t  mainReq;
   memSysPkg::mainResp_t mainResp;

   // all hit, miss and error handling sits in the cache
   dataCache uCache (
      .clk      (clk),
      .rstN     (rstN),
      .req      (req),
      .resp     (resp),
      .mainReq  (mainReq),
      .mainResp (mainResp)
   );

   // backing store for fills and write-through
   mainMemory uMainMem (
      .clk      (clk),
      .rstN     (rstN),
      .mainReq  (mainReq),
      .mainResp (mainResp)
   );

   // pipeline must hold command, address and data through a stall
   // the cache only samples once, so a change here is lost
   reqStable: assert property (@(posedge clk) disable iff (!rstN)
      resp.stall |=> $stable(req));

endmodule

`default_nettype wire

// ==== hw/mainMemory.sv ====
// fixed latency main memory
`timescale 1ns/1ns
`default_nettype none

module mainMemory (
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire memSysPkg::mainReq_t mainReq,
   output memSysPkg::mainResp_t     mainResp
);

   // word storage
   cpuIsaPkg::word_t memArray [memSysPkg::MEM_WORDS];
   cpuIsaPkg::word_t rdataQ;

   // cycles since the request first appeared
   logic [memSysPkg::LAT_CNT_W-1:0] latCnt;
   logic                            active;
   logic                            latDone;

   // memory starts cleared
   initial begin
      for (int i = 0; i < memSysPkg::MEM_WORDS; i++) begin
         memArray[i] = '0;
      end
   end

   assign active  = mainReq.rd || mainReq.wr;
   assign latDone = active && (latCnt == memSysPkg::MEM_LATENCY);

   // back to zero on completion so a follow-on request counts fresh
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) latCnt <= '0;
      else if (!active || latDone) latCnt <= '0;
      else latCnt <= latCnt + 1'b1;
   end

   // read port sampled every cycle, address is stable while pending
   always_ff @(posedge clk) begin
      rdataQ <= memArray[mainReq.addr];
   end

   // write lands only at the end of the latency
   always @(posedge clk) begin
      if (latDone && mainReq.wr) memArray[mainReq.addr] <= mainReq.wdata;
   end

   assign mainResp.valid = latDone;
   assign mainResp.rdata = rdataQ;

   // requester holds address and command until valid
   addrStable: assert property (@(posedge clk) disable iff (!rstN)
      (active && !latDone) |=> (active && $stable(mainReq.addr)));

endmodule

`default_nettype wire

// ==== hw/dataCache.sv ====
// direct-mapped write-through data cache
`timescale 1ns/1ns
`default_nettype none

module dataCache (
   input  wire logic                 clk,
   input  wire logic                 rstN,
   input  wire memSysPkg::memReq_t   req,
   output memSysPkg::memResp_t       resp,
   output memSysPkg::mainReq_t       mainReq,
   input  wire memSysPkg::mainResp_t mainResp
);

   typedef enum logic [2:0] {
      sIdle,
      sCompare,
      sFill0,
      sFill1,
      sWriteThru,
      sRespond
   } cacheState_t;

   cacheState_t state;
   cacheState_t stateNext;

   // line storage
   logic [memSysPkg::LINES-1:0] lineValid;
   logic [memSysPkg::TAG_W-1:0] lineTag [memSysPkg::LINES];
   cpuIsaPkg::word_t lineData [memSysPkg::LINES][memSysPkg::WORDS_PER_LINE];

   // request captured in idle
   cpuIsaPkg::word_t addrQ;
   cpuIsaPkg::word_t wdataQ;
   // status for the respond state
   logic hitQ;
   logic errQ;

   // address fields
   logic [memSysPkg::INDEX_W-1:0]                    index;
   logic [memSysPkg::TAG_W-1:0]                      tag;
   logic                                             wordSel;
   logic [cpuIsaPkg::WORD_W-memSysPkg::OFFSET_W-1:0] blockAddr;
   logic                                             tagHit;

   assign index     = addrQ[memSysPkg::OFFSET_W +: memSysPkg::INDEX_W];
   assign tag       = addrQ[memSysPkg::OFFSET_W + memSysPkg::INDEX_W +: memSysPkg::TAG_W];
   // byte bit 0 is always clear here, bit 1 picks the word
   assign wordSel   = addrQ[memSysPkg::OFFSET_W-1];
   assign blockAddr = addrQ[cpuIsaPkg::WORD_W-1:memSysPkg::OFFSET_W];
   assign tagHit    = lineValid[index] && (lineTag[index] == tag);

   always_comb begin
      stateNext = state;
      case (state)
         sIdle: begin
            // rd and wr together is answered with err only
            if (req.rd && req.wr) stateNext = sRespond;
            else if (req.rd) stateNext = sCompare;
            else if (req.wr) stateNext = sWriteThru;
         end
         sCompare:   stateNext = tagHit ? sIdle : sFill0;
         sFill0:     if (mainResp.valid) stateNext = sFill1;
         sFill1:     if (mainResp.valid) stateNext = sIdle;
         sWriteThru: if (mainResp.valid) stateNext = sRespond;
         default:    stateNext = sIdle;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state     <= sIdle;
         lineValid <= '0;
         hitQ      <= 1'b0;
         errQ      <= 1'b0;
      end else begin
         state <= stateNext;
         if (state == sIdle) begin
            hitQ <= 1'b0;
            errQ <= req.rd && req.wr;
         end
         // write hit is reported with the late done
         if (state == sWriteThru && mainResp.valid) hitQ <= tagHit;
         // line becomes valid once both words are in
         if (state == sFill1 && mainResp.valid) lineValid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state == sIdle) begin
         addrQ  <= req.addr;
         wdataQ <= req.wdata;
      end
      if (mainResp.valid) begin
         case (state)
            sFill0: lineData[index][0] <= mainResp.rdata;
            sFill1: begin
               lineData[index][1] <= mainResp.rdata;
               lineTag[index]     <= tag;
            end
            // no allocate, only refresh a present line
            sWriteThru: if (tagHit) lineData[index][wordSel] <= wdataQ;
            default: ;
         endcase
      end
   end

   always_comb begin
      // fetch starts already in compare to save a cycle on a miss
      mainReq.rd    = (state == sCompare && !tagHit) || state == sFill0 || state == sFill1;
      mainReq.wr    = (state == sWriteThru);
      mainReq.wdata = wdataQ;
      if (state == sWriteThru) mainReq.addr = {blockAddr, wordSel};
      else mainReq.addr = {blockAddr, state == sFill1};
   end

   always_comb begin
      resp.done  = (state == sCompare && tagHit) || (state == sFill1 && mainResp.valid)
                   || state == sRespond;
      resp.hit   = (state == sCompare && tagHit) || (state == sRespond && hitQ);
      resp.err   = (state == sRespond) && errQ;
      // stall drops in the done cycle
      resp.stall = (state == sCompare && !tagHit) || state == sFill0
                   || (state == sFill1 && !mainResp.valid) || state == sWriteThru;
      // word 1 of a fill is bypassed straight from memory
      resp.rdata = (state == sFill1 && wordSel) ? mainResp.rdata : lineData[index][wordSel];
   end

   doneSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
      resp.done |=> !resp.done);

   mainReqExclusive: assert property (@(posedge clk) disable iff (!rstN)
      !(mainReq.rd && mainReq.wr));

   idleNoStall: assert property (@(posedge clk) disable iff (!rstN)
      (state == sIdle) |-> !resp.stall);

endmodule

`default_nettype wire

// ==== hw/nextPcUnit.sv ====
// next program counter select
`timescale 1ns/1ns
`default_nettype none

module nextPcUnit (
   input  wire cpuIsaPkg::pcIn_t   pcIn,
   input  wire cpuIsaPkg::pcCtrl_t pcCtrl,
   output cpuIsaPkg::word_t        nextPc,
   output logic                    flush
);

   // chosen branch offset
   cpuIsaPkg::word_t immSel;
   // pc-relative target
   cpuIsaPkg::word_t brchTarget;
   // pc after the branch decision
   cpuIsaPkg::word_t brchPc;

   // 11-bit form for jumps with a long offset
   assign immSel = pcCtrl.immSrc ? pcIn.imm11Ext : pcIn.imm8Ext;

   // offset is relative to the incremented pc
   // immediates arrive already sign extended
   assign brchTarget = pcIn.pcAdd + immSel;

   // fall through unless the branch resolved taken
   assign brchPc = pcCtrl.brchCnd ? brchTarget : pcIn.pcAdd;

   // register jump wins over any branch
   assign nextPc = pcCtrl.aluJump ? pcIn.aluResult : brchPc;

   // any redirect kills the younger stages
   assign flush = pcCtrl.brchCnd || pcCtrl.aluJump;

endmodule

`default_nettype wire

// ==== hw/memSysPkg.sv ====
// data memory system types
`default_nettype none

package memSysPkg;

   // cache geometry
   localparam int LINES          = 16;
   localparam int WORDS_PER_LINE = 2;
   localparam int INDEX_W        = $clog2(LINES);
   // byte bits inside a line
   localparam int OFFSET_W       = $clog2(WORDS_PER_LINE * 2);
   localparam int TAG_W          = cpuIsaPkg::WORD_W - INDEX_W - OFFSET_W;

   // main memory
   localparam int MEM_LATENCY = 4;
   localparam int MEM_WORDS   = 32768;
   localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);
   // counter covers 0..MEM_LATENCY
   localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

   // pipeline side request, held while stall is high
   typedef struct packed {
      logic             rd;
      logic             wr;
      cpuIsaPkg::word_t addr;
      cpuIsaPkg::word_t wdata;
   } memReq_t;

   // pipeline side response
   typedef struct packed {
      cpuIsaPkg::word_t rdata;
      logic             done;
      logic             stall;
      logic             hit;
      logic             err;
   } memResp_t;

   // cache to main memory, word addressed
   typedef struct packed {
      logic                  rd;
      logic                  wr;
      logic [MEM_ADDR_W-1:0] addr;
      cpuIsaPkg::word_t      wdata;
   } mainReq_t;

   typedef struct packed {
      cpuIsaPkg::word_t rdata;
      logic             valid;
   } mainResp_t;

endpackage

`default_nettype wire

// ==== hw/cpuIsaPkg.sv ====
// processor datapath types
`default_nettype none

package cpuIsaPkg;

   // datapath width
   // one word, also the byte address width
   localparam int WORD_W = 16;

   // basic machine word
   typedef logic [WORD_W-1:0] word_t;

   // pc redirect controls from decode and execute
   typedef struct packed {
      // 1 picks the 11-bit immediate, 0 the 8-bit one
      logic immSrc;
      // branch taken
      logic brchCnd;
      // jump target comes from the alu
      logic aluJump;
   } pcCtrl_t;

   // pc operands reaching the memory stage
   typedef struct packed {
      // pc + 2 from fetch
      word_t pcAdd;
      // sign-extended 8-bit immediate
      word_t imm8Ext;
      // sign-extended 11-bit immediate
      word_t imm11Ext;
      // jump target, also the data address
      word_t aluResult;
   } pcIn_t;

endpackage

`default_nettype wire
